/* isaPkg.sv */
package isaPkg;

	// one instruction word seen as R-type or I-type fields
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rView;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} iView;
	} instrWord_t;

	// major opcodes
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm = 6'b000001;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opJal = 6'b000011;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBne = 6'b000101;
	localparam logic [5:0] opBlez = 6'b000110;
	localparam logic [5:0] opBgtz = 6'b000111;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opLb = 6'b100000;
	localparam logic [5:0] opLh = 6'b100001;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opLbu = 6'b100100;
	localparam logic [5:0] opLhu = 6'b100101;
	localparam logic [5:0] opSb = 6'b101000;
	localparam logic [5:0] opSh = 6'b101001;
	localparam logic [5:0] opSw = 6'b101011;

	// SPECIAL function codes
	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnJr = 6'b001000;
	localparam logic [5:0] fnJalr = 6'b001001;
	localparam logic [5:0] fnSyscall = 6'b001100;
	localparam logic [5:0] fnBreak = 6'b001101;
	localparam logic [5:0] fnSync = 6'b001111;
	localparam logic [5:0] fnMfhi = 6'b010000;
	localparam logic [5:0] fnMthi = 6'b010001;
	localparam logic [5:0] fnMflo = 6'b010010;
	localparam logic [5:0] fnMtlo = 6'b010011;
	localparam logic [5:0] fnMult = 6'b011000;
	localparam logic [5:0] fnMultu = 6'b011001;
	localparam logic [5:0] fnDiv = 6'b011010;
	localparam logic [5:0] fnDivu = 6'b011011;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	// REGIMM sub-operations in rt
	localparam logic [4:0] rtBltz = 5'b00000;
	localparam logic [4:0] rtBgez = 5'b00001;
	localparam logic [4:0] rtBltzal = 5'b10000;
	localparam logic [4:0] rtBgezal = 5'b10001;

	// ALU operations
	localparam logic [4:0] aluAdd = 5'd0;
	localparam logic [4:0] aluSub = 5'd1;
	localparam logic [4:0] aluOr = 5'd2;
	localparam logic [4:0] aluAnd = 5'd3;
	localparam logic [4:0] aluNor = 5'd4;
	localparam logic [4:0] aluXor = 5'd5;
	localparam logic [4:0] aluSll = 5'd6;
	localparam logic [4:0] aluSrl = 5'd7;
	localparam logic [4:0] aluSra = 5'd8;
	localparam logic [4:0] aluSlt = 5'd9;
	localparam logic [4:0] aluSltu = 5'd10;
	localparam logic [4:0] aluAddu = 5'd12;
	localparam logic [4:0] aluSubu = 5'd16;
	localparam logic [4:0] aluNone = 5'd31;

	// multiply/divide unit operations
	localparam logic [3:0] mdMultu = 4'd0;
	localparam logic [3:0] mdMult = 4'd1;
	localparam logic [3:0] mdDivu = 4'd2;
	localparam logic [3:0] mdDiv = 4'd3;

	// HI/LO write source
	localparam logic [1:0] hiloWrLo = 2'd0;
	localparam logic [1:0] hiloWrHi = 2'd1;
	localparam logic [1:0] hiloWrMd = 2'd2;

	// immediate extension
	localparam logic [1:0] extZero = 2'd0;
	localparam logic [1:0] extSign = 2'd1;
	localparam logic [1:0] extUpper = 2'd2;

	// data-memory access size with stores low and loads high
	localparam logic [2:0] dmStByte = 3'd0;
	localparam logic [2:0] dmStHalf = 3'd1;
	localparam logic [2:0] dmStWord = 3'd2;
	localparam logic [2:0] dmLdByteU = 3'd3;
	localparam logic [2:0] dmLdByte = 3'd4;
	localparam logic [2:0] dmLdHalfU = 3'd5;
	localparam logic [2:0] dmLdHalf = 3'd6;
	localparam logic [2:0] dmLdWord = 3'd7;

	// next-PC operation
	localparam logic [1:0] npcSeq = 2'd0;
	localparam logic [1:0] npcBranch = 2'd1;
	localparam logic [1:0] npcJump = 2'd2;
	localparam logic [1:0] npcJumpReg = 2'd3;

	// predictor hints
	localparam logic [1:0] brNone = 2'd0;
	localparam logic [1:0] brReturn = 2'd1;
	localparam logic [1:0] brOther = 2'd2;
	localparam logic [1:0] brCall = 2'd3;
	localparam logic [1:0] jNone = 2'd0;
	localparam logic [1:0] jImm = 2'd1;
	localparam logic [1:0] jReg = 2'd2;

	// write-back source and destination
	localparam logic [2:0] wbHilo = 3'd0;
	localparam logic [2:0] wbImm = 3'd1;
	localparam logic [2:0] wbAlu = 3'd2;
	localparam logic [2:0] wbLink = 3'd3;
	localparam logic [2:0] wbMem = 3'd4;
	localparam logic [1:0] dstRt = 2'd0;
	localparam logic [1:0] dstRd = 2'd1;
	localparam logic [1:0] dstRa = 2'd2;

	// sign of rs where any other value means zero
	localparam logic [1:0] cmpPos = 2'b01;
	localparam logic [1:0] cmpNeg = 2'b10;

	localparam logic [4:0] excRi = 5'd10;
	localparam logic [4:0] excBp = 5'd9;
	localparam logic [4:0] excSys = 5'd8;

	localparam logic [4:0] regRa = 5'd31;

endpackage

/* aluDecoder.sv */
module aluDecoder (
	input isaPkg::instrWord_t instr,
	output logic [4:0] aluOp,
	output logic aluShamtSel,
	output logic [1:0] extOp,
	output logic aluSrcImm
);

	always_comb begin
		aluOp = isaPkg::aluNone;
		case (instr.rView.op)
			isaPkg::opSpecial: begin
				case (instr.rView.funct)
					isaPkg::fnAdd: aluOp = isaPkg::aluAdd;
					isaPkg::fnAddu: aluOp = isaPkg::aluAddu;
					isaPkg::fnSub: aluOp = isaPkg::aluSub;
					isaPkg::fnSubu: aluOp = isaPkg::aluSubu;
					isaPkg::fnAnd: aluOp = isaPkg::aluAnd;
					isaPkg::fnOr: aluOp = isaPkg::aluOr;
					isaPkg::fnXor: aluOp = isaPkg::aluXor;
					isaPkg::fnNor: aluOp = isaPkg::aluNor;
					isaPkg::fnSll, isaPkg::fnSllv: aluOp = isaPkg::aluSll;
					isaPkg::fnSrl, isaPkg::fnSrlv: aluOp = isaPkg::aluSrl;
					isaPkg::fnSra, isaPkg::fnSrav: aluOp = isaPkg::aluSra;
					isaPkg::fnSlt: aluOp = isaPkg::aluSlt;
					isaPkg::fnSltu: aluOp = isaPkg::aluSltu;
					default: aluOp = isaPkg::aluNone;
				endcase
			end
			isaPkg::opAddi: aluOp = isaPkg::aluAdd;
			isaPkg::opAddiu: aluOp = isaPkg::aluAddu;
			isaPkg::opSlti: aluOp = isaPkg::aluSlt;
			isaPkg::opSltiu: aluOp = isaPkg::aluSltu;
			isaPkg::opAndi: aluOp = isaPkg::aluAnd;
			isaPkg::opOri: aluOp = isaPkg::aluOr;
			isaPkg::opXori: aluOp = isaPkg::aluXor;
			// address calculation for loads and stores
			isaPkg::opLb, isaPkg::opLbu, isaPkg::opLh, isaPkg::opLhu, isaPkg::opLw,
			isaPkg::opSb, isaPkg::opSh, isaPkg::opSw: aluOp = isaPkg::aluAdd;
			default: aluOp = isaPkg::aluNone;
		endcase
	end

	// constant shifts take shamt as operand A
	assign aluShamtSel = (instr.rView.op == isaPkg::opSpecial) &&
		(instr.rView.funct == isaPkg::fnSll || instr.rView.funct == isaPkg::fnSrl ||
		instr.rView.funct == isaPkg::fnSra);

	always_comb begin
		case (instr.iView.op)
			isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori: extOp = isaPkg::extZero;
			isaPkg::opLui: extOp = isaPkg::extUpper;
			isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
			isaPkg::opLb, isaPkg::opLbu, isaPkg::opLh, isaPkg::opLhu, isaPkg::opLw,
			isaPkg::opSb, isaPkg::opSh, isaPkg::opSw: extOp = isaPkg::extSign;
			default: extOp = isaPkg::extZero;
		endcase
	end

	assign aluSrcImm = (instr.iView.op != isaPkg::opSpecial);

endmodule

/* memDecoder.sv */
module memDecoder (
	input isaPkg::instrWord_t instr,
	output logic dmWr,
	output logic dmRd,
	output logic [2:0] dmSel,
	output logic dcacheEn
);

	always_comb begin
		dmWr = 1'b0;
		dmRd = 1'b0;
		// word load size when nothing else applies
		dmSel = isaPkg::dmLdWord;
		case (instr.iView.op)
			isaPkg::opSb: begin
				dmWr = 1'b1;
				dmSel = isaPkg::dmStByte;
			end
			isaPkg::opSh: begin
				dmWr = 1'b1;
				dmSel = isaPkg::dmStHalf;
			end
			isaPkg::opSw: begin
				dmWr = 1'b1;
				dmSel = isaPkg::dmStWord;
			end
			isaPkg::opLbu: begin
				dmRd = 1'b1;
				dmSel = isaPkg::dmLdByteU;
			end
			isaPkg::opLb: begin
				dmRd = 1'b1;
				dmSel = isaPkg::dmLdByte;
			end
			isaPkg::opLhu: begin
				dmRd = 1'b1;
				dmSel = isaPkg::dmLdHalfU;
			end
			isaPkg::opLh: begin
				dmRd = 1'b1;
				dmSel = isaPkg::dmLdHalf;
			end
			isaPkg::opLw: dmRd = 1'b1;
			default: dmRd = 1'b0;
		endcase
	end

	assign dcacheEn = dmWr | dmRd;

endmodule

/* branchUnit.sv */
module branchUnit (
	input isaPkg::instrWord_t instr,
	input logic rsNeRt,
	input logic [1:0] cmpSign,
	output logic isBranch,
	output logic [1:0] brType,
	output logic [1:0] jType,
	output logic [1:0] npcOp
);

	logic condBranch;
	logic taken;

	always_comb begin
		isBranch = 1'b0;
		condBranch = 1'b0;
		taken = 1'b0;
		brType = isaPkg::brNone;
		jType = isaPkg::jNone;
		case (instr.iView.op)
			isaPkg::opBeq, isaPkg::opBne: begin
				isBranch = 1'b1;
				condBranch = 1'b1;
				brType = isaPkg::brOther;
				// BNE is the only odd opcode of the pair
				taken = rsNeRt == instr.iView.op[0];
			end
			isaPkg::opBlez: begin
				isBranch = 1'b1;
				condBranch = 1'b1;
				brType = isaPkg::brOther;
				taken = (cmpSign != isaPkg::cmpPos);
			end
			isaPkg::opBgtz: begin
				isBranch = 1'b1;
				condBranch = 1'b1;
				brType = isaPkg::brOther;
				taken = (cmpSign == isaPkg::cmpPos);
			end
			isaPkg::opRegimm: begin
				case (instr.iView.rt)
					isaPkg::rtBgez, isaPkg::rtBgezal: begin
						isBranch = 1'b1;
						condBranch = 1'b1;
						taken = (cmpSign != isaPkg::cmpNeg);
					end
					isaPkg::rtBltz, isaPkg::rtBltzal: begin
						isBranch = 1'b1;
						condBranch = 1'b1;
						taken = (cmpSign == isaPkg::cmpNeg);
					end
					default: isBranch = 1'b0;
				endcase
				// linking forms look like calls to the predictor
				if (isBranch)
					brType = instr.iView.rt[4] ? isaPkg::brCall : isaPkg::brOther;
			end
			isaPkg::opJ: begin
				isBranch = 1'b1;
				brType = isaPkg::brOther;
				jType = isaPkg::jImm;
			end
			isaPkg::opJal: begin
				isBranch = 1'b1;
				brType = isaPkg::brCall;
				jType = isaPkg::jImm;
			end
			isaPkg::opSpecial: begin
				if (instr.rView.funct == isaPkg::fnJr || instr.rView.funct == isaPkg::fnJalr) begin
					isBranch = 1'b1;
					jType = isaPkg::jReg;
					// jr $31 is a return
					if (instr.rView.funct == isaPkg::fnJr && instr.rView.rs == isaPkg::regRa)
						brType = isaPkg::brReturn;
					else
						brType = isaPkg::brOther;
				end
			end
			default: isBranch = 1'b0;
		endcase
	end

	always_comb begin
		if (condBranch)
			npcOp = taken ? isaPkg::npcBranch : isaPkg::npcSeq;
		else if (jType == isaPkg::jImm)
			npcOp = isaPkg::npcJump;
		else if (jType == isaPkg::jReg)
			npcOp = isaPkg::npcJumpReg;
		else
			npcOp = isaPkg::npcSeq;
	end

endmodule

/* hiloDecoder.sv */
module hiloDecoder (
	input isaPkg::instrWord_t instr,
	output logic hiloWr,
	output logic hiloRdSel,
	output logic [1:0] hiloWrSel,
	output logic hiloUse,
	output logic mdStart,
	output logic [3:0] mdOp
);

	logic isSpecial;

	assign isSpecial = (instr.rView.op == isaPkg::opSpecial);

	always_comb begin
		hiloWr = 1'b0;
		hiloRdSel = 1'b0;
		hiloWrSel = isaPkg::hiloWrLo;
		hiloUse = 1'b0;
		mdStart = 1'b0;
		mdOp = isaPkg::mdMultu;
		if (isSpecial) begin
			case (instr.rView.funct)
				isaPkg::fnMfhi: begin
					hiloUse = 1'b1;
					hiloRdSel = 1'b1;
				end
				isaPkg::fnMflo: hiloUse = 1'b1;
				isaPkg::fnMthi: begin
					hiloUse = 1'b1;
					hiloWr = 1'b1;
					hiloWrSel = isaPkg::hiloWrHi;
				end
				isaPkg::fnMtlo: begin
					hiloUse = 1'b1;
					hiloWr = 1'b1;
				end
				isaPkg::fnMult, isaPkg::fnMultu, isaPkg::fnDiv, isaPkg::fnDivu: begin
					hiloUse = 1'b1;
					hiloWr = 1'b1;
					hiloWrSel = isaPkg::hiloWrMd;
					mdStart = 1'b1;
					// funct low bits give divide and unsigned
					case (instr.rView.funct)
						isaPkg::fnMult: mdOp = isaPkg::mdMult;
						isaPkg::fnDivu: mdOp = isaPkg::mdDivu;
						isaPkg::fnDiv: mdOp = isaPkg::mdDiv;
						default: mdOp = isaPkg::mdMultu;
					endcase
				end
				default: hiloUse = 1'b0;
			endcase
		end
	end

endmodule

/* writebackDecoder.sv */
module writebackDecoder (
	input isaPkg::instrWord_t instr,
	output logic rfWr,
	output logic [1:0] dstSel,
	output logic [2:0] wbSel
);

	always_comb begin
		rfWr = 1'b0;
		dstSel = isaPkg::dstRt;
		wbSel = isaPkg::wbAlu;
		case (instr.rView.op)
			isaPkg::opSpecial: begin
				dstSel = isaPkg::dstRd;
				case (instr.rView.funct)
					isaPkg::fnAdd, isaPkg::fnAddu, isaPkg::fnSub, isaPkg::fnSubu,
					isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnNor,
					isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra,
					isaPkg::fnSllv, isaPkg::fnSrlv, isaPkg::fnSrav,
					isaPkg::fnSlt, isaPkg::fnSltu: rfWr = 1'b1;
					isaPkg::fnJalr: begin
						rfWr = 1'b1;
						wbSel = isaPkg::wbLink;
					end
					isaPkg::fnMfhi, isaPkg::fnMflo: begin
						rfWr = 1'b1;
						wbSel = isaPkg::wbHilo;
					end
					default: rfWr = 1'b0;
				endcase
			end
			isaPkg::opRegimm: begin
				// only the linking branches write $31
				if (instr.iView.rt == isaPkg::rtBgezal || instr.iView.rt == isaPkg::rtBltzal) begin
					rfWr = 1'b1;
					dstSel = isaPkg::dstRa;
					wbSel = isaPkg::wbLink;
				end
			end
			isaPkg::opJal: begin
				rfWr = 1'b1;
				dstSel = isaPkg::dstRa;
				wbSel = isaPkg::wbLink;
			end
			isaPkg::opLui: begin
				rfWr = 1'b1;
				wbSel = isaPkg::wbImm;
			end
			isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
			isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori: rfWr = 1'b1;
			isaPkg::opLb, isaPkg::opLbu, isaPkg::opLh, isaPkg::opLhu, isaPkg::opLw: begin
				rfWr = 1'b1;
				wbSel = isaPkg::wbMem;
			end
			default: rfWr = 1'b0;
		endcase
	end

endmodule

/* exceptionCheck.sv */
module exceptionCheck (
	input logic clk,
	input logic rst,
	input isaPkg::instrWord_t instr,
	input logic ifFlush,
	input logic fetchExc,
	input logic [4:0] fetchExcCode,
	input logic rfWr,
	input logic hiloWr,
	input logic dmWr,
	input logic isBranch,
	input logic aluRecognized,
	output logic excValid,
	output logic [4:0] excCode
);

	logic rstSign;
	logic isSpecial;
	logic isBreak;
	logic isSyscall;
	logic isSync;
	logic recognized;

	// high through reset and one cycle past it to mask RI on stale fetch data
	always_ff @(posedge clk) begin
		if (!rst)
			rstSign <= 1'b1;
		else
			rstSign <= 1'b0;
	end

	assign isSpecial = (instr.rView.op == isaPkg::opSpecial);
	assign isBreak = isSpecial && (instr.rView.funct == isaPkg::fnBreak);
	assign isSyscall = isSpecial && (instr.rView.funct == isaPkg::fnSyscall);
	assign isSync = isSpecial && (instr.rView.funct == isaPkg::fnSync);

	assign recognized = rfWr | hiloWr | dmWr | isBranch | aluRecognized |
		isBreak | isSyscall | isSync;

	// earlier stage exceptions win over decode ones
	always_comb begin
		excValid = 1'b1;
		if (fetchExc)
			excCode = fetchExcCode;
		else if (!recognized && !rstSign && !ifFlush)
			excCode = isaPkg::excRi;
		else if (isBreak)
			excCode = isaPkg::excBp;
		else if (isSyscall)
			excCode = isaPkg::excSys;
		else begin
			excValid = 1'b0;
			excCode = 5'd0;
		end
	end

endmodule

/* instrDecoder.sv */
module instrDecoder (
	input logic clk,
	input logic rst,
	input isaPkg::instrWord_t instr,
	input logic rsNeRt,
	input logic [1:0] cmpSign,
	input logic ifFlush,
	input logic fetchExc,
	input logic [4:0] fetchExcCode,
	output logic [4:0] aluOp,
	output logic aluShamtSel,
	output logic [1:0] extOp,
	output logic aluSrcImm,
	output logic dmWr,
	output logic dmRd,
	output logic [2:0] dmSel,
	output logic dcacheEn,
	output logic isBranch,
	output logic [1:0] brType,
	output logic [1:0] jType,
	output logic [1:0] npcOp,
	output logic hiloWr,
	output logic hiloRdSel,
	output logic [1:0] hiloWrSel,
	output logic hiloUse,
	output logic mdStart,
	output logic [3:0] mdOp,
	output logic rfWr,
	output logic [1:0] dstSel,
	output logic [2:0] wbSel,
	output logic excValid,
	output logic [4:0] excCode
);

	logic aluRecognized;

	// any real ALU use counts as a known instruction
	assign aluRecognized = (aluOp != isaPkg::aluNone);

	aluDecoder aluDec_i (
		.instr(instr),
		.aluOp(aluOp),
		.aluShamtSel(aluShamtSel),
		.extOp(extOp),
		.aluSrcImm(aluSrcImm)
	);

	memDecoder memDec_i (
		.instr(instr),
		.dmWr(dmWr),
		.dmRd(dmRd),
		.dmSel(dmSel),
		.dcacheEn(dcacheEn)
	);

	branchUnit branch_i (
		.instr(instr),
		.rsNeRt(rsNeRt),
		.cmpSign(cmpSign),
		.isBranch(isBranch),
		.brType(brType),
		.jType(jType),
		.npcOp(npcOp)
	);

	hiloDecoder hiloDec_i (
		.instr(instr),
		.hiloWr(hiloWr),
		.hiloRdSel(hiloRdSel),
		.hiloWrSel(hiloWrSel),
		.hiloUse(hiloUse),
		.mdStart(mdStart),
		.mdOp(mdOp)
	);

	writebackDecoder wbDec_i (
		.instr(instr),
		.rfWr(rfWr),
		.dstSel(dstSel),
		.wbSel(wbSel)
	);

	exceptionCheck excChk_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.ifFlush(ifFlush),
		.fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode),
		.rfWr(rfWr),
		.hiloWr(hiloWr),
		.dmWr(dmWr),
		.isBranch(isBranch),
		.aluRecognized(aluRecognized),
		.excValid(excValid),
		.excCode(excCode)
	);

endmodule

/* tb_instrDecoder.sv */
module tb_instrDecoder;

	logic clk;
	logic rst;
	isaPkg::instrWord_t instr;
	logic rsNeRt;
	logic [1:0] cmpSign;
	logic ifFlush;
	logic fetchExc;
	logic [4:0] fetchExcCode;

	logic [4:0] aluOp;
	logic aluShamtSel;
	logic [1:0] extOp;
	logic aluSrcImm;
	logic dmWr;
	logic dmRd;
	logic [2:0] dmSel;
	logic dcacheEn;
	logic isBranch;
	logic [1:0] brType;
	logic [1:0] jType;
	logic [1:0] npcOp;
	logic hiloWr;
	logic hiloRdSel;
	logic [1:0] hiloWrSel;
	logic hiloUse;
	logic mdStart;
	logic [3:0] mdOp;
	logic rfWr;
	logic [1:0] dstSel;
	logic [2:0] wbSel;
	logic excValid;
	logic [4:0] excCode;

	// one parsed line of six stimulus columns then fifteen expected values
	logic [31:0] field [21];
	string lines[$];
	string line;
	int fd;
	int errorCount;
	int caseCount;
	int limit;
	bit loaded;
	bit lineOk;

	instrDecoder dut_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.rsNeRt(rsNeRt),
		.cmpSign(cmpSign),
		.ifFlush(ifFlush),
		.fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode),
		.aluOp(aluOp),
		.aluShamtSel(aluShamtSel),
		.extOp(extOp),
		.aluSrcImm(aluSrcImm),
		.dmWr(dmWr),
		.dmRd(dmRd),
		.dmSel(dmSel),
		.dcacheEn(dcacheEn),
		.isBranch(isBranch),
		.brType(brType),
		.jType(jType),
		.npcOp(npcOp),
		.hiloWr(hiloWr),
		.hiloRdSel(hiloRdSel),
		.hiloWrSel(hiloWrSel),
		.hiloUse(hiloUse),
		.mdStart(mdStart),
		.mdOp(mdOp),
		.rfWr(rfWr),
		.dstSel(dstSel),
		.wbSel(wbSel),
		.excValid(excValid),
		.excCode(excCode)
	);

	always #10 clk = ~clk;

	task reportMismatch(input int idx, input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errorCount++;
		$display("FAIL %0t case %0d: %s is %0h, expected %0h", $time, idx, name, got, exp);
	endtask

	// keeps every line that is not a comment or blank
	task loadCases();
		fd = $fopen("decode_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open decode_cases.txt for reading");
			errorCount++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
			if (lines.size() == 0) begin
				$display("decode_cases.txt holds no cases");
				errorCount++;
			end
		end
	endtask

	task applyCase(input int idx);
		int n;
		n = $sscanf(lines[idx], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			field[0], field[1], field[2], field[3], field[4], field[5], field[6],
			field[7], field[8], field[9], field[10], field[11], field[12], field[13],
			field[14], field[15], field[16], field[17], field[18], field[19], field[20]);
		lineOk = (n == 21);
		if (!lineOk) begin
			$display("case %0d has a malformed line in decode_cases.txt", idx);
			errorCount++;
		end else begin
			instr = field[0];
			rsNeRt = field[1][0];
			cmpSign = field[2][1:0];
			fetchExc = field[3][0];
			fetchExcCode = field[4][4:0];
			ifFlush = field[5][0];
		end
	endtask

	task checkCase(input int idx);
		if (32'(aluOp) !== field[6]) reportMismatch(idx, "aluOp", 32'(aluOp), field[6]);
		if (32'(extOp) !== field[7]) reportMismatch(idx, "extOp", 32'(extOp), field[7]);
		if (32'(dmSel) !== field[8]) reportMismatch(idx, "dmSel", 32'(dmSel), field[8]);
		if (32'(dmWr) !== field[9]) reportMismatch(idx, "dmWr", 32'(dmWr), field[9]);
		if (32'(dmRd) !== field[10]) reportMismatch(idx, "dmRd", 32'(dmRd), field[10]);
		if (32'(npcOp) !== field[11]) reportMismatch(idx, "npcOp", 32'(npcOp), field[11]);
		if (32'(brType) !== field[12]) reportMismatch(idx, "brType", 32'(brType), field[12]);
		if (32'(rfWr) !== field[13]) reportMismatch(idx, "rfWr", 32'(rfWr), field[13]);
		if (32'(dstSel) !== field[14]) reportMismatch(idx, "dstSel", 32'(dstSel), field[14]);
		if (32'(wbSel) !== field[15]) reportMismatch(idx, "wbSel", 32'(wbSel), field[15]);
		if (32'(hiloWr) !== field[16]) reportMismatch(idx, "hiloWr", 32'(hiloWr), field[16]);
		if (32'(mdStart) !== field[17]) reportMismatch(idx, "mdStart", 32'(mdStart), field[17]);
		if (32'(mdOp) !== field[18]) reportMismatch(idx, "mdOp", 32'(mdOp), field[18]);
		if (32'(excValid) !== field[19])
			reportMismatch(idx, "excValid", 32'(excValid), field[19]);
		if (32'(excCode) !== field[20]) reportMismatch(idx, "excCode", 32'(excCode), field[20]);
	endtask

	// side outputs follow from the listed expected values and the opcode fields
	task checkDerivedOutputs(input int idx);
		logic special;
		logic [5:0] fn;
		logic expSrcImm;
		logic expShamtSel;
		logic expDcacheEn;
		logic expIsBranch;
		logic [1:0] expJType;
		logic expHiloUse;
		logic expHiloRdSel;
		logic [1:0] expHiloWrSel;
		special = (instr.rView.op == isaPkg::opSpecial);
		fn = instr.rView.funct;
		expSrcImm = !special;
		expShamtSel = special && (fn == isaPkg::fnSll || fn == isaPkg::fnSrl ||
			fn == isaPkg::fnSra);
		expDcacheEn = field[9][0] | field[10][0];
		expIsBranch = (field[12][1:0] != isaPkg::brNone);
		case (field[11][1:0])
			isaPkg::npcJump: expJType = isaPkg::jImm;
			isaPkg::npcJumpReg: expJType = isaPkg::jReg;
			default: expJType = isaPkg::jNone;
		endcase
		expHiloUse = field[16][0] | (field[13][0] && field[15][2:0] == isaPkg::wbHilo);
		expHiloRdSel = special && (fn == isaPkg::fnMfhi);
		if (field[17][0])
			expHiloWrSel = isaPkg::hiloWrMd;
		else if (special && fn == isaPkg::fnMthi)
			expHiloWrSel = isaPkg::hiloWrHi;
		else
			expHiloWrSel = isaPkg::hiloWrLo;
		if (aluSrcImm !== expSrcImm)
			reportMismatch(idx, "aluSrcImm", 32'(aluSrcImm), 32'(expSrcImm));
		if (aluShamtSel !== expShamtSel)
			reportMismatch(idx, "aluShamtSel", 32'(aluShamtSel), 32'(expShamtSel));
		if (dcacheEn !== expDcacheEn)
			reportMismatch(idx, "dcacheEn", 32'(dcacheEn), 32'(expDcacheEn));
		if (isBranch !== expIsBranch)
			reportMismatch(idx, "isBranch", 32'(isBranch), 32'(expIsBranch));
		if (jType !== expJType)
			reportMismatch(idx, "jType", 32'(jType), 32'(expJType));
		if (hiloUse !== expHiloUse)
			reportMismatch(idx, "hiloUse", 32'(hiloUse), 32'(expHiloUse));
		if (hiloRdSel !== expHiloRdSel)
			reportMismatch(idx, "hiloRdSel", 32'(hiloRdSel), 32'(expHiloRdSel));
		if (hiloWrSel !== expHiloWrSel)
			reportMismatch(idx, "hiloWrSel", 32'(hiloWrSel), 32'(expHiloWrSel));
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		instr = '0;
		rsNeRt = 1'b0;
		cmpSign = 2'b00;
		ifFlush = 1'b0;
		fetchExc = 1'b0;
		fetchExcCode = 5'd0;
		errorCount = 0;
		caseCount = 0;
		lineOk = 1'b0;
		loaded = 1'b0;
		loadCases();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		// first case lands in the cycle right after reset release
		#2;
		rst = 1'b1;
		for (int i = 0; i < lines.size(); i++) begin
			if (i > 0) begin
				@(posedge clk);
				#2;
			end
			applyCase(i);
			#16;
			if (lineOk) begin
				checkCase(i);
				checkDerivedOutputs(i);
			end
			caseCount++;
		end
		$display("cases run: %0d, errors: %0d", caseCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog sized from the number of cases
	initial begin
		wait (loaded);
		limit = (4 + 2 + lines.size()) * 20 * 2;
		#(limit);
		errorCount++;
		$display("timeout: the run did not finish within %0d time units", limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* decode_cases.txt */
# instr rsNeRt cmpSign fetchExc fetchExcCode ifFlush, all hex, then expected:
# aluOp extOp dmSel dmWr dmRd npcOp brType rfWr dstSel wbSel hiloWr mdStart mdOp excValid excCode
FC000000 0 0 0 00 0 1f 0 7 0 0 0 0 0 0 2 0 0 0 0 00
00221821 0 0 0 00 0 0c 0 7 0 0 0 0 1 1 2 0 0 0 0 00
000220C0 0 0 0 00 0 06 0 7 0 0 0 0 1 1 2 0 0 0 0 00
342500FF 0 0 0 00 0 02 0 7 0 0 0 0 1 0 2 0 0 0 0 00
2826FFFF 0 0 0 00 0 09 1 7 0 0 0 0 1 0 2 0 0 0 0 00
3C071234 0 0 0 00 0 1f 2 7 0 0 0 0 1 0 1 0 0 0 0 00
80280004 0 0 0 00 0 00 1 4 0 1 0 0 1 0 4 0 0 0 0 00
94290002 0 0 0 00 0 00 1 5 0 1 0 0 1 0 4 0 0 0 0 00
8C2A0008 0 0 0 00 0 00 1 7 0 1 0 0 1 0 4 0 0 0 0 00
A0220000 0 0 0 00 0 00 1 0 1 0 0 0 0 0 2 0 0 0 0 00
AC22000C 0 0 0 00 0 00 1 2 1 0 0 0 0 0 2 0 0 0 0 00
10220004 0 0 0 00 0 1f 0 7 0 0 1 2 0 0 2 0 0 0 0 00
10220004 1 0 0 00 0 1f 0 7 0 0 0 2 0 0 2 0 0 0 0 00
14220004 1 0 0 00 0 1f 0 7 0 0 1 2 0 0 2 0 0 0 0 00
14220004 0 0 0 00 0 1f 0 7 0 0 0 2 0 0 2 0 0 0 0 00
04210004 0 1 0 00 0 1f 0 7 0 0 1 2 0 0 2 0 0 0 0 00
04210004 0 2 0 00 0 1f 0 7 0 0 0 2 0 0 2 0 0 0 0 00
04200004 0 2 0 00 0 1f 0 7 0 0 1 2 0 0 2 0 0 0 0 00
04200004 0 0 0 00 0 1f 0 7 0 0 0 2 0 0 2 0 0 0 0 00
18200004 0 0 0 00 0 1f 0 7 0 0 1 2 0 0 2 0 0 0 0 00
18200004 0 1 0 00 0 1f 0 7 0 0 0 2 0 0 2 0 0 0 0 00
1C200004 0 1 0 00 0 1f 0 7 0 0 1 2 0 0 2 0 0 0 0 00
1C200004 0 3 0 00 0 1f 0 7 0 0 0 2 0 0 2 0 0 0 0 00
08000010 0 0 0 00 0 1f 0 7 0 0 2 2 0 0 2 0 0 0 0 00
03E00008 0 0 0 00 0 1f 0 7 0 0 3 1 0 1 2 0 0 0 0 00
0C000010 0 0 0 00 0 1f 0 7 0 0 2 3 1 2 3 0 0 0 0 00
00220018 0 0 0 00 0 1f 0 7 0 0 0 0 0 1 2 1 1 1 0 00
0022001B 0 0 0 00 0 1f 0 7 0 0 0 0 0 1 2 1 1 2 0 00
00005810 0 0 0 00 0 1f 0 7 0 0 0 0 1 1 0 0 0 0 0 00
FC000000 0 0 0 00 0 1f 0 7 0 0 0 0 0 0 2 0 0 0 1 0a
FC000000 0 0 0 00 1 1f 0 7 0 0 0 0 0 0 2 0 0 0 0 00
0000000D 0 0 0 00 0 1f 0 7 0 0 0 0 0 1 2 0 0 0 1 09
0000000C 0 0 0 00 0 1f 0 7 0 0 0 0 0 1 2 0 0 0 1 08
FC000000 0 0 1 04 0 1f 0 7 0 0 0 0 0 0 2 0 0 0 1 04
0000000D 0 0 1 06 0 1f 0 7 0 0 0 0 0 1 2 0 0 0 1 06

/* project.f */
isaPkg.sv
aluDecoder.sv
memDecoder.sv
branchUnit.sv
hiloDecoder.sv
writebackDecoder.sv
exceptionCheck.sv
instrDecoder.sv
tb_instrDecoder.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f project.f --top-module tb_instrDecoder -o tb_instrDecoder
out=$(./obj_dir/tb_instrDecoder)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"
